// File: decode_stage.f
design/rv_isa_pkg.sv
design/decode_pkg.sv
design/instr_classifier.sv
design/operand_hazard_check.sv
design/decode_stage_reg.sv
design/decode_stage.sv
sim/decode_stage_tb.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= decode_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

    import rv_isa_pkg::*;
    import decode_pkg::*;

    // Tests take roughly 450 cycles
    localparam int MAX_CYCLES = 2000;

    logic          clk;
    logic          rst_n;
    logic          f2d_valid;
    fetch_pkt_t    f2d_pkt;
    logic          e2d_ready;
    pipeline_cmd_e e2d_cmd;
    word_t         e2d_jump_target;
    rd_claim_t     e2d_claim;
    logic          d2f_ready;
    pipeline_cmd_e d2f_cmd;
    word_t         d2f_jump_target;
    logic          d2e_valid;
    fetch_pkt_t    d2e_pkt;
    decode_ctrl_t  d2e_ctrl;
    logic          rs1_read;
    logic          rs2_read;
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;

    // Reference side
    decode_ctrl_t  exp_ctrl;
    decode_ctrl_t  acc_ctrl;
    fetch_pkt_t    acc_pkt;
    logic          taken;
    logic          stall_exp;
    logic [31:0]   rng;
    int            cycles = 0;
    int            errors;
    int            test_errors;
    int            tests;
    string         test_name;
    // ALU op per funct3 with the base funct7
    alu_sel_e      f3_alu [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                  ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    // M extension op per funct3
    muldiv_sel_e   f3_muldiv [8] = '{MULDIV_MUL, MULDIV_MULH, MULDIV_MULHSU, MULDIV_MULHU,
                                     MULDIV_DIV, MULDIV_DIVU, MULDIV_REM, MULDIV_REMU};
    pipeline_cmd_e redirects [3] = '{CMD_KILL, CMD_FLUSH, CMD_BRANCH};

    decode_stage dut0 (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Expected control bundle from the encoding rules
    function automatic decode_ctrl_t ctrl_ref(input word_t ins);
        decode_ctrl_t c;
        opcode_t      op;
        funct3_t      f3;
        funct7_t      f7;
        logic         ok;
        op = ins[6:0];
        f3 = ins[14:12];
        f7 = ins[31:25];
        c  = '{INSTR_NOP, ALU_ADD, MULDIV_MUL, IN0_RS1, IN1_RS2, SHAMT_RS2, RD_ALU, 1'b0};
        ok = 1'b1;
        if (op == OPC_OP && f7 == FUNCT7_MULDIV) begin
            c.instr_type = INSTR_MULDIV;
            c.muldiv_sel = f3_muldiv[f3];
            c.rd_sel     = RD_MULDIV;
        end else if (op == OPC_OP) begin
            // Alternate funct7 only for SUB and SRA
            ok = f7 == FUNCT7_BASE || (f7 == FUNCT7_ALT && f3 inside {3'b000, 3'b101});
            c.instr_type = INSTR_ALU;
            c.alu_sel    = (f7 != FUNCT7_ALT) ? f3_alu[f3] : (f3 == 3'b000 ? ALU_SUB : ALU_SRA);
        end else if (op == OPC_OP_IMM) begin
            ok = !(f3 == 3'b001 && f7 != FUNCT7_BASE) &&
                 !(f3 == 3'b101 && f7 != FUNCT7_BASE && f7 != FUNCT7_ALT);
            c.instr_type = INSTR_ALU;
            c.alu_sel    = (f3 == 3'b101 && f7 == FUNCT7_ALT) ? ALU_SRA : f3_alu[f3];
            c.in1_sel    = IN1_SIMM12;
            c.shamt_sel  = SHAMT_IMM;
        end else if (op == OPC_LUI) begin
            c.instr_type = INSTR_ALU;
            c.rd_sel     = RD_LUI;
        end else if (op == OPC_AUIPC) begin
            c.instr_type = INSTR_ALU;
            c.in0_sel    = IN0_PC;
            c.in1_sel    = IN1_CONST4;
        end else if (op == OPC_JAL || op == OPC_JALR) begin
            ok = op == OPC_JAL || f3 == 3'b000;
            c.instr_type = INSTR_JUMP;
            c.in0_sel    = (op == OPC_JAL) ? IN0_PC : IN0_RS1;
            c.in1_sel    = (op == OPC_JAL) ? IN1_JAL_OFFSET : IN1_SIMM12;
        end else if (op == OPC_BRANCH) begin
            c.instr_type = INSTR_BRANCH;
            c.in0_sel    = IN0_PC;
            c.in1_sel    = IN1_BRANCH_OFFSET;
        end else if (op == OPC_LOAD) begin
            c.instr_type = INSTR_LOAD;
            c.in1_sel    = IN1_SIMM12;
            c.rd_sel     = RD_MEMORY;
        end else if (op == OPC_STORE) begin
            ok = !f3[2];
            c.instr_type = INSTR_STORE;
            c.in1_sel    = IN1_STORE_OFFSET;
        end else begin
            ok = 1'b0;
        end
        if (!ok) begin
            c = '{INSTR_NOP, ALU_ADD, MULDIV_MUL, IN0_RS1, IN1_RS2, SHAMT_RS2, RD_ALU, 1'b1};
        end
        return c;
    endfunction

    // Expected stall from source usage and the pending write
    function automatic logic hazard_ref(input word_t ins, input rd_claim_t cl);
        logic uses1;
        logic uses2;
        uses1 = ins[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_JALR, OPC_BRANCH, OPC_LOAD};
        uses2 = ins[6:0] inside {OPC_OP, OPC_BRANCH, OPC_STORE};
        return cl.write && ((uses1 && ins[19:15] == cl.waddr) ||
                            (uses2 && ins[24:20] == cl.waddr));
    endfunction

    assign stall_exp = hazard_ref(f2d_pkt.instr, e2d_claim);

    // What the item taken at this edge should decode to
    always @(posedge clk) begin
        taken <= rs1_read;
        if (rs1_read) begin
            acc_ctrl <= exp_ctrl;
            acc_pkt  <= f2d_pkt;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [127:0] exp,
                                   input logic [127:0] act);
        errors++;
        $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR %s: %s", test_name, what);
    endtask

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !d2e_valid && !d2f_ready && !rs1_read && !rs2_read)
        else report_error("outputs not idle after reset");
    a_no_read_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !f2d_valid |-> !rs1_read && !rs2_read)
        else report_error("register read strobe without a fetch item");
    a_empty_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!f2d_valid && !d2e_valid) |-> !d2f_ready)
        else report_error("fetch ready raised by an empty stage with nothing to take");
    a_decode_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
        rs1_read |=> d2e_ctrl == acc_ctrl)
        else report_mismatch("d2e_ctrl", 128'(acc_ctrl), 128'(d2e_ctrl));
    a_decode_pkt: assert property (@(posedge clk) disable iff (!rst_n)
        rs1_read |=> d2e_valid && d2e_pkt == acc_pkt)
        else report_mismatch("d2e_pkt", 128'(acc_pkt), 128'(d2e_pkt));
    a_rs_addr: assert property (@(posedge clk) disable iff (!rst_n)
        rs1_addr == f2d_pkt.instr[19:15] && rs2_addr == f2d_pkt.instr[24:20])
        else report_mismatch("rs addr", 128'(f2d_pkt.instr[24:15]), 128'({rs2_addr, rs1_addr}));
    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (f2d_valid && stall_exp && e2d_cmd == CMD_NONE) |-> !d2f_ready && !rs1_read)
        else report_error("instruction taken while a source register is pending");
    a_accept_free: assert property (@(posedge clk) disable iff (!rst_n)
        (f2d_valid && !stall_exp && !d2e_valid) |-> d2f_ready && rs1_read && rs2_read)
        else report_error("empty stage did not take an instruction without a hazard");
    a_bp_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (d2e_valid && !e2d_ready) |-> !d2f_ready)
        else report_error("fetch ready raised under back-pressure");
    a_bp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (d2e_valid && !e2d_ready) |=> d2e_valid && $stable(d2e_pkt) && $stable(d2e_ctrl))
        else report_error("decode output changed under back-pressure");
    a_cmd_pass: assert property (@(posedge clk) disable iff (!rst_n)
        d2f_cmd == e2d_cmd && d2f_jump_target == e2d_jump_target)
        else report_mismatch("d2f_cmd and d2f_jump_target",
                             128'({e2d_cmd, e2d_jump_target}),
                             128'({d2f_cmd, d2f_jump_target}));
    a_cmd_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (d2e_valid && e2d_ready && e2d_cmd != CMD_NONE) |-> d2f_ready ##1 !d2e_valid)
        else report_error("redirect did not drop the held instruction");

    task automatic drive_fetch(input word_t instr);
        word_t w;
        @(negedge clk);
        w = rand_word();
        f2d_pkt.instr                 = instr;
        f2d_pkt.pc                    = {w[31:2], 2'b00};
        f2d_pkt.interrupt_pending     = w[0];
        f2d_pkt.fetch_exception       = w[1];
        f2d_pkt.fetch_exception_cause = rand_word();
        f2d_valid                     = 1'b1;
        exp_ctrl                      = ctrl_ref(instr);
    endtask

    task automatic wait_taken();
        do @(negedge clk); while (!taken);
        f2d_valid = 1'b0;
    endtask

    task automatic issue(input word_t instr);
        drive_fetch(instr);
        wait_taken();
    endtask

    // Pending write on waddr for a few cycles, then released
    task automatic hazard_case(input word_t instr, input reg_addr_t waddr);
        int n;
        drive_fetch(instr);
        e2d_claim = '{1'b1, waddr};
        n = 0;
        while (!taken && n < 3) begin
            @(negedge clk);
            n++;
        end
        e2d_claim.write = 1'b0;
        if (taken) begin
            f2d_valid = 1'b0;
        end else begin
            wait_taken();
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("%s done, %0d error(s)", test_name, errors - test_errors);
        tests++;
    endtask

    initial begin
        word_t   w;
        funct7_t f7;
        int      i;
        rng             = 32'h248107d0;
        errors          = 0;
        tests           = 0;
        rst_n           = 1'b0;
        f2d_valid       = 1'b0;
        f2d_pkt         = '0;
        e2d_ready       = 1'b1;
        e2d_cmd         = CMD_NONE;
        e2d_jump_target = '0;
        e2d_claim       = '0;
        exp_ctrl        = '0;

        start_test("reset");
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        end_test();

        // OP and OP-IMM with base, alt, M and random funct7
        start_test("arith");
        for (i = 0; i < 100; i++) begin
            w = rand_word();
            case (w[1:0])
                2'd0:    f7 = FUNCT7_BASE;
                2'd1:    f7 = FUNCT7_ALT;
                2'd2:    f7 = FUNCT7_MULDIV;
                default: f7 = w[31:25];
            endcase
            issue({f7, w[24:7], w[2] ? OPC_OP : OPC_OP_IMM});
        end
        end_test();

        start_test("classes");
        for (i = 0; i < 8; i++) begin
            w = rand_word();
            issue({w[31:7], OPC_LUI});
            issue({w[31:7], OPC_AUIPC});
            issue({w[31:7], OPC_JAL});
            issue({w[31:15], 3'b000, w[11:7], OPC_JALR});
            issue({w[31:15], w[14:13], 1'b1, w[11:7], OPC_JALR});
            issue({w[31:7], OPC_BRANCH});
            issue({w[31:7], OPC_LOAD});
            issue({w[31:15], 1'b0, w[13:7], OPC_STORE});
            issue({w[31:15], 1'b1, w[13:7], OPC_STORE});
            do w = rand_word(); while (w[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI,
                OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE});
            issue(w);
        end
        end_test();

        start_test("hazard");
        // ADD x1, x5, x9
        w = {FUNCT7_BASE, 5'd9, 5'd5, 3'b000, 5'd1, OPC_OP};
        hazard_case(w, 5'd5);
        hazard_case(w, 5'd9);
        hazard_case(w, 5'd1);
        // x0 source still counts
        hazard_case({7'd0, 5'd7, 5'd0, 3'b000, 5'd3, OPC_OP_IMM}, 5'd0);
        // Immediate bits in the rs2 field
        hazard_case({7'd0, 5'd7, 5'd2, 3'b000, 5'd3, OPC_OP_IMM}, 5'd7);
        hazard_case({12'h0, 5'd5, 3'b000, 5'd4, OPC_LUI}, 5'd5);
        hazard_case({7'd0, 5'd6, 5'd2, 3'b010, 5'd0, OPC_STORE}, 5'd6);
        end_test();

        start_test("backpressure");
        @(negedge clk);
        e2d_ready = 1'b0;
        issue({w[31:7], OPC_LOAD});
        // Next item waits behind the held one
        drive_fetch({FUNCT7_ALT, w[24:15], 3'b000, w[11:7], OPC_OP});
        repeat (4) @(negedge clk);
        e2d_ready = 1'b1;
        wait_taken();
        end_test();

        start_test("commands");
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            e2d_ready = 1'b0;
            w = rand_word();
            issue({w[31:7], OPC_JAL});
            // Redirect while holding, with a fetch item on offer
            e2d_cmd         = redirects[i];
            e2d_jump_target = rand_word();
            e2d_ready       = 1'b1;
            f2d_valid       = 1'b1;
            @(negedge clk);
            e2d_cmd   = CMD_NONE;
            f2d_valid = 1'b0;
        end
        end_test();

        @(negedge clk);
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      f2d_valid,
    input  decode_pkg::fetch_pkt_t    f2d_pkt,
    input  logic                      e2d_ready,
    input  decode_pkg::pipeline_cmd_e e2d_cmd,
    input  rv_isa_pkg::word_t         e2d_jump_target,
    input  decode_pkg::rd_claim_t     e2d_claim,
    output logic                      d2f_ready,
    output decode_pkg::pipeline_cmd_e d2f_cmd,
    output rv_isa_pkg::word_t         d2f_jump_target,
    output logic                      d2e_valid,
    output decode_pkg::fetch_pkt_t    d2e_pkt,
    output decode_pkg::decode_ctrl_t  d2e_ctrl,
    output logic                      rs1_read,
    output rv_isa_pkg::reg_addr_t     rs1_addr,
    output logic                      rs2_read,
    output rv_isa_pkg::reg_addr_t     rs2_addr
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    decode_ctrl_t ctrl_next;
    logic         stall;

    // Register file addresses straight from the fetched word
    assign rs1_addr = f2d_pkt.instr[RS1_LSB +: $bits(reg_addr_t)];
    assign rs2_addr = f2d_pkt.instr[RS2_LSB +: $bits(reg_addr_t)];

    // Redirects from execute go to fetch unregistered
    assign d2f_cmd         = e2d_cmd;
    assign d2f_jump_target = e2d_jump_target;

    // Classification and hazard check run side by side
    instr_classifier u_classifier (
        .instr     (f2d_pkt.instr),
        .ctrl_next (ctrl_next)
    );

    operand_hazard_check u_hazard (
        .instr (f2d_pkt.instr),
        .claim (e2d_claim),
        .stall (stall)
    );

    decode_stage_reg u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .f2d_valid (f2d_valid),
        .f2d_pkt   (f2d_pkt),
        .ctrl_next (ctrl_next),
        .stall     (stall),
        .e2d_ready (e2d_ready),
        .e2d_cmd   (e2d_cmd),
        .d2f_ready (d2f_ready),
        .rs1_read  (rs1_read),
        .rs2_read  (rs2_read),
        .d2e_valid (d2e_valid),
        .d2e_pkt   (d2e_pkt),
        .d2e_ctrl  (d2e_ctrl)
    );

endmodule

`default_nettype wire

// File: design/decode_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      f2d_valid,
    input  decode_pkg::fetch_pkt_t    f2d_pkt,
    input  decode_pkg::decode_ctrl_t  ctrl_next,
    input  logic                      stall,
    input  logic                      e2d_ready,
    input  decode_pkg::pipeline_cmd_e e2d_cmd,
    output logic                      d2f_ready,
    output logic                      rs1_read,
    output logic                      rs2_read,
    output logic                      d2e_valid,
    output decode_pkg::fetch_pkt_t    d2e_pkt,
    output decode_pkg::decode_ctrl_t  d2e_ctrl
);

    import decode_pkg::*;

    logic accept;
    logic valid_next;

    always_comb begin
        accept     = 1'b0;
        valid_next = d2e_valid;
        d2f_ready  = 1'b0;
        if (!d2e_valid) begin
            // Empty stage takes anything without a stale operand
            if (f2d_valid && !stall) begin
                accept     = 1'b1;
                valid_next = 1'b1;
                d2f_ready  = 1'b1;
            end
        end else if (e2d_ready) begin
            if (f2d_valid && e2d_cmd == CMD_NONE) begin
                if (stall) begin
                    // Current one leaves, next waits for its operand
                    valid_next = 1'b0;
                end else begin
                    accept     = 1'b1;
                    valid_next = 1'b1;
                    d2f_ready  = 1'b1;
                end
            end else begin
                // Nothing fetched, or kill/flush/branch discards the fetch item
                valid_next = 1'b0;
                d2f_ready  = 1'b1;
            end
        end
        // Holding with e2d_ready low keeps everything
    end

    // Register file read only for the instruction being taken
    assign rs1_read = accept;
    assign rs2_read = accept;

    always_ff @(posedge clk) begin
        if (accept) begin
            d2e_pkt  <= f2d_pkt;
            d2e_ctrl <= ctrl_next;
        end
        // Reset overrides the flags loaded above
        if (!rst_n) begin
            d2e_valid                 <= 1'b0;
            d2e_pkt.interrupt_pending <= 1'b0;
            d2e_pkt.fetch_exception   <= 1'b0;
        end else begin
            d2e_valid <= valid_next;
        end
    end

    // Register reads only happen together with a fetch handshake
    a_read_with_ready: assert property (
        @(posedge clk) disable iff (!rst_n) rs1_read |-> d2f_ready
    );

    // Execute sees a stable packet while it stalls
    a_hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n) (d2e_valid && !e2d_ready) |=> $stable(d2e_pkt)
    );

endmodule

`default_nettype wire

// File: design/operand_hazard_check.sv
`timescale 1ns/1ps
`default_nettype none

module operand_hazard_check (
    input  rv_isa_pkg::word_t     instr,
    input  decode_pkg::rd_claim_t claim,
    output logic                  stall
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    opcode_t   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      rs1_used;
    logic      rs2_used;
    logic      rs1_stale;
    logic      rs2_stale;

    assign opcode = instr[6:0];
    assign rs1    = instr[RS1_LSB +: $bits(reg_addr_t)];
    assign rs2    = instr[RS2_LSB +: $bits(reg_addr_t)];

    // Classes that read rs1
    assign rs1_used = opcode inside {OPC_OP, OPC_OP_IMM, OPC_JALR, OPC_BRANCH, OPC_LOAD};
    // Classes that read rs2
    assign rs2_used = opcode inside {OPC_OP, OPC_BRANCH, OPC_STORE};

    // x0 is not filtered out
    assign rs1_stale = rs1_used && claim.write && (rs1 == claim.waddr);
    assign rs2_stale = rs2_used && claim.write && (rs2 == claim.waddr);

    // Hold back until execute has written the register
    assign stall = rs1_stale || rs2_stale;

    always_comb begin
        // A stall needs an outstanding write from execute
        a_stall_needs_claim: assert (!stall || claim.write);
    end

endmodule

`default_nettype wire

// File: design/instr_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module instr_classifier (
    input  rv_isa_pkg::word_t        instr,
    output decode_pkg::decode_ctrl_t ctrl_next
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    alt;
    logic    op_ok;
    logic    op_imm_ok;

    // Shared funct3 to ALU op table for OP and OP-IMM
    function automatic alu_sel_e alu_op(input funct3_t f3, input logic sub_sra);
        alu_sel_e sel;
        case (f3)
            3'b000:  sel = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  sel = ALU_SLL;
            3'b010:  sel = ALU_SLT;
            3'b011:  sel = ALU_SLTU;
            3'b100:  sel = ALU_XOR;
            3'b101:  sel = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  sel = ALU_OR;
            default: sel = ALU_AND;
        endcase
        return sel;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign alt    = (funct7 == FUNCT7_ALT);

    // R-type: base funct7 for all, alt only for SUB and SRA
    assign op_ok = (funct7 == FUNCT7_BASE) ||
                   (alt && (funct3 == 3'b000 || funct3 == 3'b101));

    // Immediate forms; only the shifts constrain funct7
    assign op_imm_ok = (funct3 == 3'b001) ? (funct7 == FUNCT7_BASE) :
                       (funct3 == 3'b101) ? (funct7 == FUNCT7_BASE || alt) :
                       1'b1;

    always_comb begin
        // Illegal until a legal pattern matches
        ctrl_next.instr_type = INSTR_NOP;
        ctrl_next.alu_sel    = ALU_ADD;
        ctrl_next.muldiv_sel = MULDIV_MUL;
        ctrl_next.in0_sel    = IN0_RS1;
        ctrl_next.in1_sel    = IN1_RS2;
        ctrl_next.shamt_sel  = SHAMT_RS2;
        ctrl_next.rd_sel     = RD_ALU;
        ctrl_next.illegal    = 1'b1;
        case (opcode)
            OPC_OP: begin
                if (funct7 == FUNCT7_MULDIV) begin
                    ctrl_next.instr_type = INSTR_MULDIV;
                    // Enum follows funct3 order
                    ctrl_next.muldiv_sel = muldiv_sel_e'(funct3);
                    ctrl_next.rd_sel     = RD_MULDIV;
                    ctrl_next.illegal    = 1'b0;
                end else if (op_ok) begin
                    ctrl_next.instr_type = INSTR_ALU;
                    ctrl_next.alu_sel    = alu_op(funct3, alt);
                    ctrl_next.illegal    = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                if (op_imm_ok) begin
                    ctrl_next.instr_type = INSTR_ALU;
                    // ADDI ignores imm[11:5], only SRAI uses alt
                    ctrl_next.alu_sel    = alu_op(funct3, alt && funct3 == 3'b101);
                    ctrl_next.in1_sel    = IN1_SIMM12;
                    ctrl_next.shamt_sel  = SHAMT_IMM;
                    ctrl_next.illegal    = 1'b0;
                end
            end
            OPC_LUI: begin
                ctrl_next.instr_type = INSTR_ALU;
                ctrl_next.rd_sel     = RD_LUI;
                ctrl_next.illegal    = 1'b0;
            end
            OPC_AUIPC: begin
                ctrl_next.instr_type = INSTR_ALU;
                ctrl_next.in0_sel    = IN0_PC;
                ctrl_next.in1_sel    = IN1_CONST4;
                ctrl_next.illegal    = 1'b0;
            end
            OPC_JAL: begin
                // Target is PC plus J offset
                ctrl_next.instr_type = INSTR_JUMP;
                ctrl_next.in0_sel    = IN0_PC;
                ctrl_next.in1_sel    = IN1_JAL_OFFSET;
                ctrl_next.illegal    = 1'b0;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl_next.instr_type = INSTR_JUMP;
                    ctrl_next.in1_sel    = IN1_SIMM12;
                    ctrl_next.illegal    = 1'b0;
                end
            end
            OPC_BRANCH: begin
                ctrl_next.instr_type = INSTR_BRANCH;
                ctrl_next.in0_sel    = IN0_PC;
                ctrl_next.in1_sel    = IN1_BRANCH_OFFSET;
                ctrl_next.illegal    = 1'b0;
            end
            OPC_LOAD: begin
                ctrl_next.instr_type = INSTR_LOAD;
                ctrl_next.in1_sel    = IN1_SIMM12;
                ctrl_next.rd_sel     = RD_MEMORY;
                ctrl_next.illegal    = 1'b0;
            end
            OPC_STORE: begin
                // SB, SH, SW only
                if (!funct3[2]) begin
                    ctrl_next.instr_type = INSTR_STORE;
                    ctrl_next.in1_sel    = IN1_STORE_OFFSET;
                    ctrl_next.illegal    = 1'b0;
                end
            end
            default: begin
                ctrl_next.illegal = 1'b1;
            end
        endcase
        // Execute must never act on an illegal encoding
        a_illegal_is_nop: assert (!ctrl_next.illegal || ctrl_next.instr_type == INSTR_NOP);
    end

endmodule

`default_nettype wire

// File: design/decode_pkg.sv
`default_nettype none

package decode_pkg;

    import rv_isa_pkg::*;

    // ALU result select
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_sel_e;

    // Same order as funct3 of the M extension
    typedef enum logic [2:0] {
        MULDIV_MUL    = 3'd0,
        MULDIV_MULH   = 3'd1,
        MULDIV_MULHSU = 3'd2,
        MULDIV_MULHU  = 3'd3,
        MULDIV_DIV    = 3'd4,
        MULDIV_DIVU   = 3'd5,
        MULDIV_REM    = 3'd6,
        MULDIV_REMU   = 3'd7
    } muldiv_sel_e;

    // Instruction class seen by execute
    typedef enum logic [2:0] {
        INSTR_NOP, INSTR_ALU, INSTR_MULDIV, INSTR_JUMP,
        INSTR_BRANCH, INSTR_LOAD, INSTR_STORE
    } instr_type_e;

    // ALU operand muxes
    typedef enum logic {IN0_RS1, IN0_PC} in0_sel_e;
    typedef enum logic [2:0] {
        IN1_RS2, IN1_SIMM12, IN1_JAL_OFFSET,
        IN1_BRANCH_OFFSET, IN1_STORE_OFFSET, IN1_CONST4
    } in1_sel_e;
    typedef enum logic {SHAMT_RS2, SHAMT_IMM} shamt_sel_e;

    // Writeback source for rd
    typedef enum logic [1:0] {RD_ALU, RD_LUI, RD_MULDIV, RD_MEMORY} rd_sel_e;

    // Command from execute, forwarded to fetch
    typedef enum logic [1:0] {CMD_NONE, CMD_KILL, CMD_FLUSH, CMD_BRANCH} pipeline_cmd_e;

    // Decoded control bundle
    typedef struct packed {
        instr_type_e instr_type;
        alu_sel_e    alu_sel;
        muldiv_sel_e muldiv_sel;
        in0_sel_e    in0_sel;
        in1_sel_e    in1_sel;
        shamt_sel_e  shamt_sel;
        rd_sel_e     rd_sel;
        logic        illegal;
    } decode_ctrl_t;

    // Fetched instruction with its side information
    typedef struct packed {
        word_t instr;
        word_t pc;
        logic  interrupt_pending;
        logic  fetch_exception;
        word_t fetch_exception_cause;
    } fetch_pkt_t;

    // Register execute is about to write
    typedef struct packed {
        logic      write;
        reg_addr_t waddr;
    } rd_claim_t;

endpackage

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Architectural word width
    localparam int XLEN = 32;

    // Instruction, PC and exception cause words
    typedef logic [XLEN-1:0] word_t;
    // Integer register index, x0..x31
    typedef logic [4:0] reg_addr_t;

    // Instruction field types
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Major opcodes of the base integer set
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // funct7 variants
    localparam funct7_t FUNCT7_BASE   = 7'b0000000;
    // SUB and SRA/SRAI
    localparam funct7_t FUNCT7_ALT    = 7'b0100000;
    // M extension
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

    // Source register field positions
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

endpackage

`default_nettype wire
